//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ex_stage -f tb.f -o sim_ex_stage

out=$(./obj_dir/sim_ex_stage)
echo "$out"

if echo "$out" | grep -q "STATUS: PASS"; then
    exit 0
else
    exit 1
fi

//--- src/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu
    import ex_pkg::*;
(
    input  wire              clk_i,
    input  wire              reset_i,
    input  wire              stage_en_i,
    input  wire alu_op_e     alu_op_i,
    input  wire [XLEN-1:0]   op_left_i,
    input  wire [XLEN-1:0]   op_right_i,
    input  wire [2:0]        cmp_op_i,
    input  wire [XLEN-1:0]   cmp_left_i,
    input  wire [XLEN-1:0]   cmp_right_i,
    output logic [XLEN-1:0]  result_o,
    output logic             cmp_o
);

    logic [XLEN-1:0] result_d;
    logic            cmp_d;
    logic [4:0]      shamt;

    assign shamt = op_right_i[4:0];

    // --------------------------------------------------
    // arithmetic and logic
    // --------------------------------------------------
    always_comb begin
        case (alu_op_i)
            ALU_ADD:  result_d = op_left_i + op_right_i;
            ALU_SUB:  result_d = op_left_i - op_right_i;
            ALU_AND:  result_d = op_left_i & op_right_i;
            ALU_OR:   result_d = op_left_i | op_right_i;
            ALU_XOR:  result_d = op_left_i ^ op_right_i;
            ALU_SLL:  result_d = op_left_i << shamt;
            ALU_SRL:  result_d = op_left_i >> shamt;
            ALU_SRA:  result_d = $signed(op_left_i) >>> shamt;
            ALU_SLT:  result_d = {{(XLEN-1){1'b0}}, $signed(op_left_i) < $signed(op_right_i)};
            ALU_SLTU: result_d = {{(XLEN-1){1'b0}}, op_left_i < op_right_i};
            default:  result_d = '0;
        endcase
    end

    // --------------------------------------------------
    // branch comparator
    // --------------------------------------------------
    always_comb begin
        case (cmp_op_i)
            CMP_BEQ:  cmp_d = (cmp_left_i == cmp_right_i);
            CMP_BNE:  cmp_d = (cmp_left_i != cmp_right_i);
            CMP_BLT:  cmp_d = ($signed(cmp_left_i) < $signed(cmp_right_i));
            CMP_BGE:  cmp_d = ($signed(cmp_left_i) >= $signed(cmp_right_i));
            CMP_BLTU: cmp_d = (cmp_left_i < cmp_right_i);
            CMP_BGEU: cmp_d = (cmp_left_i >= cmp_right_i);
            default:  cmp_d = 1'b0;
        endcase
    end

    // both registers line up with the pipeline register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cmp_o <= 1'b0;
        end else if (stage_en_i) begin
            cmp_o <= cmp_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            result_o <= result_d;
        end
    end

endmodule

`default_nettype wire

//--- src/ex_commit_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ex_commit_ctrl
    import ex_pkg::*;
(
    input  wire             clk_i,
    input  wire             reset_i,
    input  wire             ids_valid_i,
    input  wire sofid_e     sofid_i,
    input  wire ex_slot_t   slot_i,
    input  wire [XLEN-1:0]  alu_result_i,
    input  wire             cmp_i,
    input  wire             trap_i,
    input  wire [XLEN-1:0]  trap_addr_i,
    input  wire [XLEN-1:0]  rtn_addr_i,
    input  wire             lsq_full_i,
    output logic            stage_en_o,
    output logic            ex_valid_o,
    output logic            commit_o,
    output logic            ids_stall_o,
    output logic            lsq_lq_wr_o,
    output logic            lsq_sq_wr_o,
    output lsq_req_t        lsq_req_o,
    output wb_t             wb_o,
    output logic            pfu_jump_o,
    output logic [XLEN-1:0] pfu_jump_addr_o
);

    sofid_e sofid_q;
    logic   jump;
    logic   lsq_access;

    // --------------------------------------------------
    // instruction qualification
    // --------------------------------------------------
    assign ex_valid_o = slot_i.valid & (sofid_q == SOFID_RUN);
    assign commit_o   = ex_valid_o & (cmp_i | ~slot_i.cond) & ~trap_i;

    // wrong-path instructions are dropped until a jump-tagged one arrives
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sofid_q <= SOFID_RUN;
        end else if (stage_en_o) begin
            if (jump) begin
                sofid_q <= SOFID_JUMP;
            end else if (ids_valid_i && sofid_i == SOFID_JUMP) begin
                sofid_q <= SOFID_RUN;
            end
        end
    end

    // --------------------------------------------------
    // stall controller
    // --------------------------------------------------
    assign lsq_access  = slot_i.lq_wr | slot_i.sq_wr;
    assign ids_stall_o = commit_o & lsq_full_i & lsq_access;
    assign stage_en_o  = ~ids_stall_o;

    // --------------------------------------------------
    // hart vectoring
    // --------------------------------------------------
    assign jump       = (commit_o & (slot_i.jump | slot_i.mret)) | trap_i;
    assign pfu_jump_o = stage_en_o & jump;

    always_comb begin
        if (trap_i) begin
            pfu_jump_addr_o = trap_addr_i;
        end else if (slot_i.mret) begin
            pfu_jump_addr_o = rtn_addr_i;
        end else begin
            pfu_jump_addr_o = {alu_result_i[XLEN-1:1], 1'b0};
        end
    end

    // --------------------------------------------------
    // commit outputs
    // --------------------------------------------------
    assign lsq_lq_wr_o = stage_en_o & commit_o & slot_i.lq_wr;
    assign lsq_sq_wr_o = stage_en_o & commit_o & slot_i.sq_wr;

    always_comb begin
        lsq_req_o.funct3     = slot_i.funct3;
        lsq_req_o.regd_addr  = slot_i.regd_addr;
        lsq_req_o.regs2_data = slot_i.regs2_data;
        lsq_req_o.addr       = alu_result_i;
    end

    always_comb begin
        wb_o.wr        = stage_en_o & commit_o & slot_i.regd_wr;
        // frees the register reserved by a load that will not issue
        wb_o.cncl_load = stage_en_o & ~commit_o & slot_i.valid & slot_i.lq_wr;
        wb_o.addr      = slot_i.regd_addr;
        // link writes the return address
        if (slot_i.link) begin
            wb_o.data = slot_i.pc_inc;
        end else begin
            wb_o.data = alu_result_i;
        end
    end

    // a redirect is never held back by the stall
    a_jump_enabled : assert property (
        @(posedge clk_i) disable iff (reset_i) jump |-> stage_en_o
    );

endmodule

`default_nettype wire

//--- src/ex_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_pipe_reg
    import ex_pkg::*;
(
    input  wire           clk_i,
    input  wire           reset_i,
    input  wire           stage_en_i,
    input  wire           valid_i,
    input  wire ex_req_t  req_i,
    output ex_slot_t      slot_o,
    output sofid_e        sofid_o
);

    ex_slot_t slot_d;
    ex_slot_t slot_q;
    logic     lq_wr_d;
    logic     sq_wr_d;
    logic     regd_wr_d;

    // incoming tag goes straight to the qualifier
    assign sofid_o = req_i.sofid;

    // --------------------------------------------------
    // zone decode
    // --------------------------------------------------
    always_comb begin
        lq_wr_d   = 1'b0;
        sq_wr_d   = 1'b0;
        regd_wr_d = 1'b0;
        case (req_i.zone)
            ZONE_LOADQ:   lq_wr_d   = 1'b1;
            ZONE_STOREQ:  sq_wr_d   = 1'b1;
            ZONE_REGFILE: regd_wr_d = 1'b1;
            default: begin
            end
        endcase
    end

    // --------------------------------------------------
    // next slot contents
    // --------------------------------------------------
    always_comb begin
        slot_d.valid      = valid_i;
        slot_d.pc         = req_i.pc;
        // ins_size counts 16-bit parcels
        slot_d.pc_inc     = req_i.pc + {{(XLEN-3){1'b0}}, req_i.ins_size, 1'b0};
        slot_d.lq_wr      = lq_wr_d;
        slot_d.sq_wr      = sq_wr_d;
        slot_d.regd_wr    = regd_wr_d;
        slot_d.cond       = req_i.cond;
        slot_d.jump       = req_i.jump;
        slot_d.link       = req_i.link;
        slot_d.ecall      = req_i.ecall;
        slot_d.mret       = req_i.mret;
        slot_d.regs2_data = req_i.regs2_data;
        slot_d.regd_addr  = req_i.regd_addr;
        slot_d.funct3     = req_i.funct3;
    end

    // only valid is cleared, the rest is payload
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            slot_q.valid <= 1'b0;
        end else if (stage_en_i) begin
            slot_q <= slot_d;
        end
    end

    assign slot_o = slot_q;

    // a latched instruction has at most one destination
    a_one_zone : assert property (
        @(posedge clk_i) disable iff (reset_i)
        slot_q.valid |-> $onehot0({slot_q.lq_wr, slot_q.sq_wr, slot_q.regd_wr})
    );

endmodule

`default_nettype wire

//--- src/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // where the result of an instruction goes
    typedef enum logic [1:0] {
        ZONE_NONE    = 2'd0,
        ZONE_LOADQ   = 2'd1,
        ZONE_STOREQ  = 2'd2,
        ZONE_REGFILE = 2'd3
    } zone_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // branch compare codes, same encoding as funct3
    typedef enum logic [2:0] {
        CMP_BEQ  = 3'b000,
        CMP_BNE  = 3'b001,
        CMP_BLT  = 3'b100,
        CMP_BGE  = 3'b101,
        CMP_BLTU = 3'b110,
        CMP_BGEU = 3'b111
    } cmp_op_e;

    typedef enum logic [0:0] {
        SOFID_RUN  = 1'b0,
        SOFID_JUMP = 1'b1
    } sofid_e;

    // mcause codes, none is the value out of reset
    typedef enum logic [XLEN-1:0] {
        CAUSE_NONE             = 32'd0,
        CAUSE_LOAD_MISALIGNED  = 32'd4,
        CAUSE_STORE_MISALIGNED = 32'd6,
        CAUSE_ECALL            = 32'd11
    } cause_e;

    typedef enum logic [2:0] {
        MEM_BYTE = 3'd0,
        MEM_HALF = 3'd1,
        MEM_WORD = 3'd2
    } mem_size_e;

    // --------------------------------------------------
    // bundles
    // --------------------------------------------------
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [1:0]            ins_size;
        sofid_e                sofid;
        zone_e                 zone;
        logic                  cond;
        logic                  jump;
        logic                  link;
        logic                  ecall;
        logic                  mret;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       operand_left;
        logic [XLEN-1:0]       operand_right;
        logic [XLEN-1:0]       regs1_data;
        logic [XLEN-1:0]       cmp_right;
        logic [XLEN-1:0]       regs2_data;
        logic [REG_ADDR_W-1:0] regd_addr;
        logic [2:0]            funct3;
    } ex_req_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       pc_inc;
        logic                  lq_wr;
        logic                  sq_wr;
        logic                  regd_wr;
        logic                  cond;
        logic                  jump;
        logic                  link;
        logic                  ecall;
        logic                  mret;
        logic [XLEN-1:0]       regs2_data;
        logic [REG_ADDR_W-1:0] regd_addr;
        logic [2:0]            funct3;
    } ex_slot_t;

    typedef struct packed {
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] regd_addr;
        logic [XLEN-1:0]       regs2_data;
        logic [XLEN-1:0]       addr;
    } lsq_req_t;

    typedef struct packed {
        logic                  wr;
        logic                  cncl_load;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

`default_nettype wire

//--- src/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage
    import ex_pkg::*;
#(
    parameter logic [XLEN-1:0] TRAP_VECTOR = 32'h100
) (
    input  wire             clk_i,
    input  wire             reset_i,
    // decoder
    input  wire             ids_valid_i,
    input  wire ex_req_t    ids_req_i,
    output logic            ids_stall_o,
    // load/store queue
    input  wire             lsq_full_i,
    output logic            lsq_lq_wr_o,
    output logic            lsq_sq_wr_o,
    output lsq_req_t        lsq_req_o,
    // register write-back
    output wb_t             wb_o,
    // prefetch redirect
    output logic            pfu_jump_o,
    output logic [XLEN-1:0] pfu_jump_addr_o,
    output logic            trap_o,
    output cause_e          trap_cause_o
);

    ex_slot_t        slot;
    sofid_e          sofid;
    logic            stage_en;
    logic            ex_valid;
    logic            commit;
    logic            alu_cmp;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] trap_addr;
    logic [XLEN-1:0] rtn_addr;

    ex_pipe_reg u_pipe_reg (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .stage_en_i (stage_en),
        .valid_i    (ids_valid_i),
        .req_i      (ids_req_i),
        .slot_o     (slot),
        .sofid_o    (sofid)
    );

    ex_alu u_alu (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .stage_en_i  (stage_en),
        .alu_op_i    (ids_req_i.alu_op),
        .op_left_i   (ids_req_i.operand_left),
        .op_right_i  (ids_req_i.operand_right),
        .cmp_op_i    (ids_req_i.funct3),
        .cmp_left_i  (ids_req_i.regs1_data),
        .cmp_right_i (ids_req_i.cmp_right),
        .result_o    (alu_result),
        .cmp_o       (alu_cmp)
    );

    ex_trap_unit #(
        .TRAP_VECTOR (TRAP_VECTOR)
    ) u_trap_unit (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .ex_valid_i   (ex_valid),
        .slot_i       (slot),
        .alu_result_i (alu_result),
        .commit_i     (commit),
        .trap_o       (trap_o),
        .trap_addr_o  (trap_addr),
        .rtn_addr_o   (rtn_addr),
        .cause_o      (trap_cause_o)
    );

    ex_commit_ctrl u_commit_ctrl (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .ids_valid_i     (ids_valid_i),
        .sofid_i         (sofid),
        .slot_i          (slot),
        .alu_result_i    (alu_result),
        .cmp_i           (alu_cmp),
        .trap_i          (trap_o),
        .trap_addr_i     (trap_addr),
        .rtn_addr_i      (rtn_addr),
        .lsq_full_i      (lsq_full_i),
        .stage_en_o      (stage_en),
        .ex_valid_o      (ex_valid),
        .commit_o        (commit),
        .ids_stall_o     (ids_stall_o),
        .lsq_lq_wr_o     (lsq_lq_wr_o),
        .lsq_sq_wr_o     (lsq_sq_wr_o),
        .lsq_req_o       (lsq_req_o),
        .wb_o            (wb_o),
        .pfu_jump_o      (pfu_jump_o),
        .pfu_jump_addr_o (pfu_jump_addr_o)
    );

endmodule

`default_nettype wire

//--- src/ex_trap_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_trap_unit
    import ex_pkg::*;
#(
    parameter logic [XLEN-1:0] TRAP_VECTOR = 32'h100
) (
    input  wire             clk_i,
    input  wire             reset_i,
    input  wire             ex_valid_i,
    input  wire ex_slot_t   slot_i,
    input  wire [XLEN-1:0]  alu_result_i,
    input  wire             commit_i,
    output logic            trap_o,
    output logic [XLEN-1:0] trap_addr_o,
    output logic [XLEN-1:0] rtn_addr_o,
    output cause_e          cause_o
);

    logic            excp_ecall;
    logic            excp_mala;
    logic            excp_masa;
    logic            misaligned;
    cause_e          cause_d;
    cause_e          cause_q;
    logic [XLEN-1:0] trap_pc_q;

    // --------------------------------------------------
    // exception detection
    // --------------------------------------------------
    // alu result is the load/store address here
    always_comb begin
        case (slot_i.funct3)
            MEM_HALF: misaligned = alu_result_i[0];
            MEM_WORD: misaligned = |alu_result_i[1:0];
            default:  misaligned = 1'b0;
        endcase
    end

    assign excp_ecall = slot_i.ecall;
    assign excp_mala  = slot_i.lq_wr & misaligned;
    assign excp_masa  = slot_i.sq_wr & misaligned;

    // a trapping slot never commits, so it never stalls the stage
    assign trap_o = ex_valid_i & (excp_ecall | excp_mala | excp_masa);

    // ecall wins, then load, then store
    always_comb begin
        if (excp_ecall) begin
            cause_d = CAUSE_ECALL;
        end else if (excp_mala) begin
            cause_d = CAUSE_LOAD_MISALIGNED;
        end else if (excp_masa) begin
            cause_d = CAUSE_STORE_MISALIGNED;
        end else begin
            cause_d = CAUSE_NONE;
        end
    end

    // --------------------------------------------------
    // trap pc and cause
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cause_q <= CAUSE_NONE;
        end else if (trap_o) begin
            cause_q <= cause_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (trap_o) begin
            trap_pc_q <= slot_i.pc;
        end
    end

    assign trap_addr_o = TRAP_VECTOR;
    assign rtn_addr_o  = trap_pc_q;
    // live cause while trapping, held one afterwards
    assign cause_o     = trap_o ? cause_d : cause_q;

    a_trap_needs_slot : assert property (
        @(posedge clk_i) disable iff (reset_i) trap_o |-> slot_i.valid
    );

    a_trap_no_commit : assert property (
        @(posedge clk_i) disable iff (reset_i) commit_i |-> !trap_o
    );

endmodule

`default_nettype wire

//--- tb.f
src/ex_pkg.sv
src/ex_alu.sv
src/ex_pipe_reg.sv
src/ex_trap_unit.sv
src/ex_commit_ctrl.sv
src/ex_stage.sv
test/tb_ex_stage.sv

//--- test/tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;
    import ex_pkg::*;

    localparam logic [XLEN-1:0] TRAP_VECTOR = 32'h100;

    logic            clk_i;
    logic            reset_i;
    logic            ids_valid_i;
    ex_req_t         ids_req_i;
    logic            ids_stall_o;
    logic            lsq_full_i;
    logic            lsq_lq_wr_o;
    logic            lsq_sq_wr_o;
    lsq_req_t        lsq_req_o;
    wb_t             wb_o;
    logic            pfu_jump_o;
    logic [XLEN-1:0] pfu_jump_addr_o;
    logic            trap_o;
    cause_e          trap_cause_o;

    string test_name;
    int    errors;
    int    tests_run;
    int    tests_failed;
    logic  timed_out;

    ex_stage uut (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .ids_valid_i     (ids_valid_i),
        .ids_req_i       (ids_req_i),
        .ids_stall_o     (ids_stall_o),
        .lsq_full_i      (lsq_full_i),
        .lsq_lq_wr_o     (lsq_lq_wr_o),
        .lsq_sq_wr_o     (lsq_sq_wr_o),
        .lsq_req_o       (lsq_req_o),
        .wb_o            (wb_o),
        .pfu_jump_o      (pfu_jump_o),
        .pfu_jump_addr_o (pfu_jump_addr_o),
        .trap_o          (trap_o),
        .trap_cause_o    (trap_cause_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic logic [XLEN-1:0] alu_model(input alu_op_e op, input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:  return 32'd0;
        endcase
    endfunction

    function automatic logic cmp_model(input logic [2:0] code, input logic [XLEN-1:0] a,
                                       input logic [XLEN-1:0] b);
        case (code)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    ex_req_t         m_req;
    logic            m_valid;
    sofid_e          m_sofid;
    logic [XLEN-1:0] m_trap_pc;

    logic [XLEN-1:0] e_alu, e_wdata, e_jaddr;
    logic            e_cmp, e_ldq, e_stq, e_rf, e_mis, e_exv, e_trap, e_commit;
    logic            e_stall, e_jump_raw, e_jump, e_wr, e_lq, e_sq, e_cncl;
    cause_e          e_cause;

    always_comb begin
        e_alu      = alu_model(m_req.alu_op, m_req.operand_left, m_req.operand_right);
        e_cmp      = cmp_model(m_req.funct3, m_req.regs1_data, m_req.cmp_right);
        e_ldq      = (m_req.zone == ZONE_LOADQ);
        e_stq      = (m_req.zone == ZONE_STOREQ);
        e_rf       = (m_req.zone == ZONE_REGFILE);
        e_mis      = (m_req.funct3 == 3'd1) ? e_alu[0] :
                     (m_req.funct3 == 3'd2) ? |e_alu[1:0] : 1'b0;
        e_exv      = m_valid && (m_sofid == SOFID_RUN);
        e_trap     = e_exv && (m_req.ecall || ((e_ldq || e_stq) && e_mis));
        e_commit   = e_exv && (e_cmp || !m_req.cond) && !e_trap;
        e_stall    = e_commit && lsq_full_i && (e_ldq || e_stq);
        e_jump_raw = (e_commit && (m_req.jump || m_req.mret)) || e_trap;
        e_jump     = !e_stall && e_jump_raw;
        e_jaddr    = e_trap ? TRAP_VECTOR : m_req.mret ? m_trap_pc : {e_alu[XLEN-1:1], 1'b0};
        e_wr       = !e_stall && e_commit && e_rf;
        e_wdata    = m_req.link ? m_req.pc + {29'd0, m_req.ins_size, 1'b0} : e_alu;
        e_lq       = !e_stall && e_commit && e_ldq;
        e_sq       = !e_stall && e_commit && e_stq;
        e_cncl     = !e_stall && !e_commit && m_valid && e_ldq;
        e_cause    = m_req.ecall ? CAUSE_ECALL :
                     (e_ldq && e_mis) ? CAUSE_LOAD_MISALIGNED : CAUSE_STORE_MISALIGNED;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            m_valid <= 1'b0;
            m_sofid <= SOFID_RUN;
        end else if (!e_stall) begin
            m_valid <= ids_valid_i;
            m_req   <= ids_req_i;
            if (e_jump_raw) begin
                m_sofid <= SOFID_JUMP;
            end else if (ids_valid_i && ids_req_i.sofid == SOFID_JUMP) begin
                m_sofid <= SOFID_RUN;
            end
        end
        if (!reset_i && e_trap) begin
            m_trap_pc <= m_req.pc;
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    task automatic report_error(input string what, input logic [XLEN-1:0] exp_v,
                                input logic [XLEN-1:0] act_v);
        errors++;
        $display("Error: test %s, %s expected %h actual %h", test_name, what, exp_v, act_v);
    endtask

    a_stall : assert property (@(posedge clk_i) disable iff (reset_i) ids_stall_o == e_stall)
        else report_error("ids_stall_o", 32'($sampled(e_stall)), 32'($sampled(ids_stall_o)));
    a_wr : assert property (@(posedge clk_i) disable iff (reset_i) wb_o.wr == e_wr)
        else report_error("wb_o.wr", 32'($sampled(e_wr)), 32'($sampled(wb_o.wr)));
    a_wdata : assert property (@(posedge clk_i) disable iff (reset_i)
        e_wr |-> wb_o.data == e_wdata)
        else report_error("wb_o.data", $sampled(e_wdata), $sampled(wb_o.data));
    a_waddr : assert property (@(posedge clk_i) disable iff (reset_i)
        e_wr |-> wb_o.addr == m_req.regd_addr)
        else report_error("wb_o.addr", 32'($sampled(m_req.regd_addr)), 32'($sampled(wb_o.addr)));
    a_lq : assert property (@(posedge clk_i) disable iff (reset_i) lsq_lq_wr_o == e_lq)
        else report_error("lsq_lq_wr_o", 32'($sampled(e_lq)), 32'($sampled(lsq_lq_wr_o)));
    a_sq : assert property (@(posedge clk_i) disable iff (reset_i) lsq_sq_wr_o == e_sq)
        else report_error("lsq_sq_wr_o", 32'($sampled(e_sq)), 32'($sampled(lsq_sq_wr_o)));
    a_lsq_addr : assert property (@(posedge clk_i) disable iff (reset_i)
        (e_lq || e_sq) |-> lsq_req_o.addr == e_alu)
        else report_error("lsq addr", $sampled(e_alu), $sampled(lsq_req_o.addr));
    a_lsq_data : assert property (@(posedge clk_i) disable iff (reset_i)
        (e_lq || e_sq) |-> lsq_req_o.regs2_data == m_req.regs2_data)
        else report_error("lsq data", $sampled(m_req.regs2_data), $sampled(lsq_req_o.regs2_data));
    a_lsq_funct3 : assert property (@(posedge clk_i) disable iff (reset_i)
        (e_lq || e_sq) |-> lsq_req_o.funct3 == m_req.funct3)
        else report_error("lsq funct3", 32'($sampled(m_req.funct3)),
                          32'($sampled(lsq_req_o.funct3)));
    a_lsq_rd : assert property (@(posedge clk_i) disable iff (reset_i)
        (e_lq || e_sq) |-> lsq_req_o.regd_addr == m_req.regd_addr)
        else report_error("lsq regd_addr", 32'($sampled(m_req.regd_addr)),
                          32'($sampled(lsq_req_o.regd_addr)));
    a_cncl : assert property (@(posedge clk_i) disable iff (reset_i) wb_o.cncl_load == e_cncl)
        else report_error("cncl_load", 32'($sampled(e_cncl)), 32'($sampled(wb_o.cncl_load)));
    a_jump : assert property (@(posedge clk_i) disable iff (reset_i) pfu_jump_o == e_jump)
        else report_error("pfu_jump_o", 32'($sampled(e_jump)), 32'($sampled(pfu_jump_o)));
    a_jaddr : assert property (@(posedge clk_i) disable iff (reset_i)
        e_jump |-> pfu_jump_addr_o == e_jaddr)
        else report_error("jump addr", $sampled(e_jaddr), $sampled(pfu_jump_addr_o));
    a_trap : assert property (@(posedge clk_i) disable iff (reset_i) trap_o == e_trap)
        else report_error("trap_o", 32'($sampled(e_trap)), 32'($sampled(trap_o)));
    a_cause : assert property (@(posedge clk_i) disable iff (reset_i)
        e_trap |-> trap_cause_o == e_cause)
        else report_error("trap cause", $sampled(e_cause), $sampled(trap_cause_o));

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    function automatic ex_req_t rand_req(input zone_e zone, input sofid_e tag);
        ex_req_t r;
        r               = '0;
        r.pc            = $urandom & 32'hffff_fffe;
        r.ins_size      = 2'd2;
        r.sofid         = tag;
        r.zone          = zone;
        r.alu_op        = ALU_ADD;
        r.operand_left  = $urandom;
        r.operand_right = $urandom;
        r.regs1_data    = $urandom;
        r.cmp_right     = $urandom;
        r.regs2_data    = $urandom;
        r.regd_addr     = 5'($urandom);
        return r;
    endfunction

    // present one instruction and wait until it is accepted
    task automatic send(input ex_req_t req);
        int waited;
        waited = 0;
        if (!timed_out) begin
            @(negedge clk_i);
            ids_valid_i = 1'b1;
            ids_req_i   = req;
            lsq_full_i  = 1'b0;
            @(posedge clk_i);
            // a stall seen at the edge means the instruction was not taken
            while (ids_stall_o && waited < 50) begin
                @(posedge clk_i);
                waited++;
            end
            if (ids_stall_o) begin
                $display("timeout: stall never cleared, instruction not accepted");
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic idle(input int n, input logic full);
        repeat (n) begin
            @(negedge clk_i);
            ids_valid_i = 1'b0;
            lsq_full_i  = full;
        end
    endtask

    task automatic start_test(input string name, output int err_start);
        test_name = name;
        err_start = errors;
    endtask

    task automatic finish_test(input int err_start);
        idle(2, 1'b0);
        tests_run++;
        if (errors != err_start) begin
            tests_failed++;
        end
        $display("test %s done, %0d errors", test_name, errors - err_start);
    endtask

    ex_req_t r;
    int      e0;
    logic [2:0] cmp_codes [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

    initial begin
        void'($urandom(32'hb009));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        ids_valid_i  = 1'b0;
        ids_req_i    = '0;
        lsq_full_i   = 1'b0;
        reset_i      = 1'b1;
        repeat (4) @(negedge clk_i);
        reset_i = 1'b0;

        start_test("alu_writeback", e0);
        for (int op = 0; op < 10; op++) begin
            repeat (3) begin
                r        = rand_req(ZONE_REGFILE, SOFID_RUN);
                r.alu_op = alu_op_e'(op);
                send(r);
            end
        end
        finish_test(e0);

        start_test("branch_link", e0);
        foreach (cmp_codes[i]) begin
            repeat (4) begin
                // every branch carries the jump tag so it runs after a taken one
                r        = rand_req(ZONE_NONE, SOFID_JUMP);
                r.cond   = 1'b1;
                r.jump   = 1'b1;
                r.funct3 = cmp_codes[i];
                if ($urandom_range(1) == 1) begin
                    r.cmp_right = r.regs1_data;
                end
                send(r);
                idle(1, 1'b0);
            end
        end
        r          = rand_req(ZONE_REGFILE, SOFID_JUMP);
        r.jump     = 1'b1;
        r.link     = 1'b1;
        r.ins_size = 2'd1;
        send(r);
        idle(1, 1'b0);
        finish_test(e0);

        start_test("wrong_path_squash", e0);
        r      = rand_req(ZONE_NONE, SOFID_JUMP);
        r.jump = 1'b1;
        send(r);
        repeat (3) send(rand_req(ZONE_REGFILE, SOFID_RUN));
        send(rand_req(ZONE_REGFILE, SOFID_JUMP));
        repeat (2) send(rand_req(ZONE_REGFILE, SOFID_RUN));
        finish_test(e0);

        start_test("lsq_backpressure", e0);
        r        = rand_req(ZONE_LOADQ, SOFID_RUN);
        r.funct3 = 3'd2;
        r.operand_right[1:0] = 2'b00;
        r.operand_left[1:0]  = 2'b00;
        send(r);
        idle(4, 1'b1);
        idle(1, 1'b0);
        r        = rand_req(ZONE_STOREQ, SOFID_RUN);
        r.funct3 = 3'd0;
        send(r);
        idle(3, 1'b1);
        idle(1, 1'b0);
        finish_test(e0);

        start_test("trap_return", e0);
        for (int k = 0; k < 3; k++) begin
            r = rand_req(ZONE_NONE, SOFID_JUMP);
            if (k == 0) begin
                r.ecall = 1'b1;
            end else if (k == 1) begin
                r.zone          = ZONE_LOADQ;
                r.funct3        = 3'd1;
                r.operand_left  = 32'h2000;
                r.operand_right = 32'h0000_0011;
            end else begin
                r.zone          = ZONE_STOREQ;
                r.funct3        = 3'd2;
                r.operand_left  = 32'h3000;
                r.operand_right = 32'h0000_0022;
            end
            send(r);
            idle(1, 1'b0);
            r      = rand_req(ZONE_NONE, SOFID_JUMP);
            r.mret = 1'b1;
            send(r);
            idle(1, 1'b0);
        end
        finish_test(e0);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
